// File: design/ts_monitor_pkg.sv
package ts_monitor_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus and packet sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int axi_addr_w = 8;     // AXI4-Lite address width
	localparam int axi_data_w = 32;    // AXI4-Lite data width

	localparam int pkt_bytes = 188;    // One transport stream packet
	localparam int pkt_words = 47;     // pkt_bytes / 4
	localparam int word_addr_w = 6;    // Word index into one bank

	localparam int pid_w = 13;
	localparam logic [7:0] sync_byte = 8'h47;

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////

	// Bit 0 is run_enable
	localparam logic [axi_addr_w-1:0] reg_ctrl = 8'h00;

	// Bits 12..0 hold the PID to match
	localparam logic [axi_addr_w-1:0] reg_pid = 8'h04;

	// Bit 0 is packet_ready
	localparam logic [axi_addr_w-1:0] reg_status = 8'h08;

	// Write 1 to bit 0 to free the held packet
	localparam logic [axi_addr_w-1:0] reg_ack = 8'h0C;

	localparam logic [axi_addr_w-1:0] reg_pkt_count = 8'h10;   // Captured packets
	localparam logic [axi_addr_w-1:0] reg_drop_count = 8'h14;  // Dropped packets

	// Packet window, 47 words from 0x40 up to 0xF8
	localparam logic [axi_addr_w-1:0] reg_data_base = 8'h40;

endpackage

// File: design/ts_sync_detector.sv
module ts_sync_detector (
	input  logic                           mpeg_clk,
	input  logic                           S_AXI_ARESETN,
	input  logic [7:0]                     mpeg_data,
	input  logic                           mpeg_valid,
	input  logic                           mpeg_sync,
	input  logic                           run_enable,
	input  logic [ts_monitor_pkg::pid_w-1:0] match_pid,
	output logic                           pkt_start,
	output logic [7:0]                     cap_byte,
	output logic                           cap_valid
);
	import ts_monitor_pkg::*;

	logic [7:0]       data_d1;
	logic [7:0]       data_d2;
	logic [7:0]       data_d3;
	logic             sync_d1;
	logic             sync_d2;
	logic             sync_d3;
	logic [pid_w-1:0] rx_pid;
	logic             hdr_match;

	////////////////////////////////////////////////////////////////////////////
	// Delay line advances on valid bytes only
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			sync_d3 <= 1'b0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
			sync_d3 <= sync_d2;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Header check on the oldest three bytes
	////////////////////////////////////////////////////////////////////////////

	// Low five bits of byte 1 and all of byte 2
	assign rx_pid = {data_d2[4:0], data_d1};

	assign hdr_match = sync_d3 && (data_d3 == sync_byte)
		&& (rx_pid == match_pid) && run_enable;

	// Start pulse rides with the sync byte itself
	assign pkt_start = mpeg_valid & hdr_match;
	assign cap_byte = data_d3;
	assign cap_valid = mpeg_valid;

endmodule

// File: design/ts_packet_capture.sv
module ts_packet_capture (
	input  logic                                 mpeg_clk,
	input  logic                                 S_AXI_ARESETN,
	input  logic                                 pkt_start,
	input  logic [7:0]                           cap_byte,
	input  logic                                 cap_valid,
	output logic                                 wr_en,
	output logic [ts_monitor_pkg::word_addr_w-1:0] wr_addr,
	output logic [ts_monitor_pkg::axi_data_w-1:0]  wr_data,
	output logic                                 pkt_done
);
	import ts_monitor_pkg::*;

	logic       active;
	logic [7:0] byte_cnt;    // Index of the next byte in the packet
	logic [23:0] lanes_lo;   // Lanes 0..2 of the word being built

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			active <= 1'b0;
			byte_cnt <= '0;
			wr_en <= 1'b0;
			pkt_done <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			pkt_done <= 1'b0;
			if (cap_valid) begin
				if (pkt_start) begin
					active <= 1'b1;          // Restart, partial packet lost
					byte_cnt <= 8'd1;
				end else if (active) begin
					byte_cnt <= byte_cnt + 8'd1;
					if (byte_cnt[1:0] == 2'd3) begin
						wr_en <= 1'b1;
					end
					if (byte_cnt == pkt_bytes - 1) begin
						active <= 1'b0;
						pkt_done <= 1'b1;    // Goes with word 46
					end
				end
			end
		end
	end

	// Byte k lands in lane k mod 4 of word k div 4
	always_ff @(posedge mpeg_clk) begin
		if (cap_valid) begin
			if (pkt_start) begin
				lanes_lo[7:0] <= cap_byte;
			end else if (active) begin
				if (byte_cnt[1:0] == 2'd3) begin
					wr_data <= {cap_byte, lanes_lo};
					wr_addr <= byte_cnt[word_addr_w+1:2];
				end else begin
					lanes_lo[8*byte_cnt[1:0] +: 8] <= cap_byte;
				end
			end
		end
	end

	a_wr_addr_range: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		wr_en |-> (wr_addr < pkt_words));

endmodule

// File: design/ts_packet_buffer.sv
module ts_packet_buffer (
	input  logic                                 mpeg_clk,
	input  logic                                 S_AXI_ARESETN,
	input  logic                                 wr_en,
	input  logic [ts_monitor_pkg::word_addr_w-1:0] wr_addr,
	input  logic [ts_monitor_pkg::axi_data_w-1:0]  wr_data,
	input  logic                                 pkt_done,
	input  logic [ts_monitor_pkg::word_addr_w-1:0] rd_addr,
	input  logic                                 pkt_release,
	output logic [ts_monitor_pkg::axi_data_w-1:0]  rd_data,
	output logic                                 pkt_ready,
	output logic                                 pkt_captured,
	output logic                                 pkt_dropped
);
	import ts_monitor_pkg::*;

	logic [axi_data_w-1:0] bank_mem [0:1][0:pkt_words-1];
	logic                  fill_bank;   // Bank being written by the capture
	logic                  held;        // Other bank owned by software

	// Completed packet either swaps in or is thrown away
	assign pkt_captured = pkt_done & ~held;
	assign pkt_dropped = pkt_done & held;
	assign pkt_ready = held;

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			fill_bank <= 1'b0;
			held <= 1'b0;
		end else begin
			if (pkt_release) begin
				held <= 1'b0;
			end
			if (pkt_captured) begin
				fill_bank <= ~fill_bank;
				held <= 1'b1;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (wr_en) begin
			bank_mem[fill_bank][wr_addr] <= wr_data;
		end
	end

	// Held bank is always the one not being filled
	always_ff @(posedge mpeg_clk) begin
		rd_data <= bank_mem[~fill_bank][rd_addr];
	end

	a_release_when_ready: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		pkt_release |-> pkt_ready);

endmodule

// File: design/ts_monitor_ctrl.sv
module ts_monitor_ctrl (
	input  logic                                 mpeg_clk,
	input  logic                                 S_AXI_ARESETN,
	input  logic [ts_monitor_pkg::axi_addr_w-1:0]  s_axi_awaddr,
	input  logic                                 s_axi_awvalid,
	output logic                                 s_axi_awready,
	input  logic [ts_monitor_pkg::axi_data_w-1:0]  s_axi_wdata,
	input  logic                                 s_axi_wvalid,
	output logic                                 s_axi_wready,
	output logic [1:0]                           s_axi_bresp,
	output logic                                 s_axi_bvalid,
	input  logic                                 s_axi_bready,
	input  logic [ts_monitor_pkg::axi_addr_w-1:0]  s_axi_araddr,
	input  logic                                 s_axi_arvalid,
	output logic                                 s_axi_arready,
	output logic [ts_monitor_pkg::axi_data_w-1:0]  s_axi_rdata,
	output logic [1:0]                           s_axi_rresp,
	output logic                                 s_axi_rvalid,
	input  logic                                 s_axi_rready,
	input  logic                                 pkt_ready,
	input  logic                                 pkt_captured,
	input  logic                                 pkt_dropped,
	input  logic [ts_monitor_pkg::axi_data_w-1:0]  rd_data,
	output logic [ts_monitor_pkg::word_addr_w-1:0] rd_addr,
	output logic                                 pkt_release,
	output logic                                 run_enable,
	output logic [ts_monitor_pkg::pid_w-1:0]       match_pid
);
	import ts_monitor_pkg::*;

	logic                  wr_fire;
	logic                  rd_fire;
	logic [axi_addr_w-1:0] rd_addr_q;   // Latched read address
	logic [axi_addr_w-1:0] win_off;
	logic                  in_window;
	logic [1:0]            rd_pipe;     // Covers the buffer read latency
	logic                  rd_busy;
	logic [axi_data_w-1:0] pkt_count;
	logic [axi_data_w-1:0] drop_count;
	logic [axi_data_w-1:0] rd_mux;

	assign wr_fire = s_axi_awvalid & s_axi_awready & s_axi_wvalid & s_axi_wready;
	assign rd_fire = s_axi_arvalid & s_axi_arready;
	assign s_axi_bresp = 2'b00;   // Always OKAY
	assign s_axi_rresp = 2'b00;

	////////////////////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			run_enable <= 1'b0;
			match_pid <= '0;
			pkt_release <= 1'b0;
		end else begin
			// Address and data are taken together, one at a time
			s_axi_awready <= s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
			s_axi_wready <= s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
			pkt_release <= 1'b0;
			if (wr_fire) begin
				s_axi_bvalid <= 1'b1;
				case (s_axi_awaddr)
					reg_ctrl: run_enable <= s_axi_wdata[0];
					reg_pid:  match_pid <= s_axi_wdata[pid_w-1:0];
					reg_ack:  pkt_release <= s_axi_wdata[0] & pkt_ready;
					default:  ;
				endcase
			end else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			pkt_count <= '0;
			drop_count <= '0;
		end else begin
			if (pkt_captured) begin
				pkt_count <= pkt_count + 1'b1;
			end
			if (pkt_dropped) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////////////////////

	assign win_off = rd_addr_q - reg_data_base;
	assign in_window = (rd_addr_q >= reg_data_base)
		&& (rd_addr_q < reg_data_base + 4 * pkt_words);
	assign rd_addr = in_window ? win_off[word_addr_w+1:2] : '0;

	always_comb begin
		case (rd_addr_q)
			reg_ctrl:       rd_mux = {{(axi_data_w-1){1'b0}}, run_enable};
			reg_pid:        rd_mux = {{(axi_data_w-pid_w){1'b0}}, match_pid};
			reg_status:     rd_mux = {{(axi_data_w-1){1'b0}}, pkt_ready};
			reg_pkt_count:  rd_mux = pkt_count;
			reg_drop_count: rd_mux = drop_count;
			default:        rd_mux = in_window ? rd_data : '0;   // Ack reads as 0 too
		endcase
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
			rd_pipe <= '0;
			rd_busy <= 1'b0;
		end else begin
			s_axi_arready <= s_axi_arvalid & ~s_axi_arready & ~rd_busy;
			rd_pipe <= {rd_pipe[0], rd_fire};
			if (rd_fire) begin
				rd_busy <= 1'b1;
			end
			if (rd_pipe[1]) begin
				s_axi_rvalid <= 1'b1;
			end else if (s_axi_rvalid && s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
				rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (rd_fire) begin
			rd_addr_q <= s_axi_araddr;
		end
		if (rd_pipe[1]) begin
			s_axi_rdata <= rd_mux;
		end
	end

	a_bvalid_hold: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	a_rvalid_hold: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// File: design/ts_monitor_top.sv
module ts_monitor_top (
	input  logic                                mpeg_clk,
	input  logic                                S_AXI_ARESETN,
	input  logic [7:0]                          mpeg_data,
	input  logic                                mpeg_valid,
	input  logic                                mpeg_sync,
	input  logic [ts_monitor_pkg::axi_addr_w-1:0] s_axi_awaddr,
	input  logic                                s_axi_awvalid,
	output logic                                s_axi_awready,
	input  logic [ts_monitor_pkg::axi_data_w-1:0] s_axi_wdata,
	input  logic                                s_axi_wvalid,
	output logic                                s_axi_wready,
	output logic [1:0]                          s_axi_bresp,
	output logic                                s_axi_bvalid,
	input  logic                                s_axi_bready,
	input  logic [ts_monitor_pkg::axi_addr_w-1:0] s_axi_araddr,
	input  logic                                s_axi_arvalid,
	output logic                                s_axi_arready,
	output logic [ts_monitor_pkg::axi_data_w-1:0] s_axi_rdata,
	output logic [1:0]                          s_axi_rresp,
	output logic                                s_axi_rvalid,
	input  logic                                s_axi_rready
);
	import ts_monitor_pkg::*;

	logic                   pkt_start;
	logic [7:0]             cap_byte;
	logic                   cap_valid;
	logic                   wr_en;
	logic [word_addr_w-1:0] wr_addr;
	logic [axi_data_w-1:0]  wr_data;
	logic                   pkt_done;
	logic [word_addr_w-1:0] rd_addr;
	logic [axi_data_w-1:0]  rd_data;
	logic                   pkt_release;
	logic                   pkt_ready;
	logic                   pkt_captured;
	logic                   pkt_dropped;
	logic                   run_enable;
	logic [pid_w-1:0]       match_pid;

	ts_sync_detector i_ts_sync_detector (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.run_enable    (run_enable),
		.match_pid     (match_pid),
		.pkt_start     (pkt_start),
		.cap_byte      (cap_byte),
		.cap_valid     (cap_valid)
	);

	ts_packet_capture i_ts_packet_capture (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.pkt_start     (pkt_start),
		.cap_byte      (cap_byte),
		.cap_valid     (cap_valid),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.pkt_done      (pkt_done)
	);

	ts_packet_buffer i_ts_packet_buffer (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.pkt_done      (pkt_done),
		.rd_addr       (rd_addr),
		.pkt_release   (pkt_release),
		.rd_data       (rd_data),
		.pkt_ready     (pkt_ready),
		.pkt_captured  (pkt_captured),
		.pkt_dropped   (pkt_dropped)
	);

	ts_monitor_ctrl i_ts_monitor_ctrl (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.pkt_ready     (pkt_ready),
		.pkt_captured  (pkt_captured),
		.pkt_dropped   (pkt_dropped),
		.rd_data       (rd_data),
		.rd_addr       (rd_addr),
		.pkt_release   (pkt_release),
		.run_enable    (run_enable),
		.match_pid     (match_pid)
	);

endmodule

// File: sim/tb_ts_monitor.sv
module tb_ts_monitor;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int wait_limit = 200;    // Cycles allowed for any handshake

	logic        mpeg_clk;
	logic        S_AXI_ARESETN;
	logic [7:0]  mpeg_data;
	logic        mpeg_valid;
	logic        mpeg_sync;
	logic [7:0]  s_axi_awaddr;
	logic        s_axi_awvalid;
	logic        s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic        s_axi_wvalid;
	logic        s_axi_wready;
	logic [1:0]  s_axi_bresp;
	logic        s_axi_bvalid;
	logic        s_axi_bready;
	logic [7:0]  s_axi_araddr;
	logic        s_axi_arvalid;
	logic        s_axi_arready;
	logic [31:0] s_axi_rdata;
	logic [1:0]  s_axi_rresp;
	logic        s_axi_rvalid;
	logic        s_axi_rready;

	integer seed = 14857;
	integer errors = 0;
	integer tests_done = 0;
	logic   timed_out = 1'b0;

	ts_monitor_top i_ts_monitor_top (.*);

	initial begin
		mpeg_clk = 1'b0;
		forever #2 mpeg_clk = ~mpeg_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks and expected data
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	// Sync byte, two PID bytes, then first + k for payload byte k
	function automatic logic [7:0] packet_byte(input logic [12:0] pid,
		input logic [7:0] first, input int k);
		case (k)
			0: return 8'h47;
			1: return {3'b000, pid[12:8]};
			2: return pid[7:0];
			default: return first + 8'(k - 3);
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite master
	////////////////////////////////////////////////////////////////////////////

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int cnt;
		cnt = 0;
		@(negedge mpeg_clk);
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		s_axi_bready = 1'b1;
		while (!s_axi_awready && cnt < wait_limit) begin
			@(negedge mpeg_clk);
			cnt++;
		end
		if (cnt == wait_limit) begin
			report_timeout("awready");
		end else begin
			check_value("s_axi_wready", s_axi_wready, 32'h1);   // Pulses with awready
		end
		@(negedge mpeg_clk);              // Address and data taken
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		cnt = 0;
		while (!s_axi_bvalid && cnt < wait_limit) begin
			@(negedge mpeg_clk);
			cnt++;
		end
		if (cnt == wait_limit) begin
			report_timeout("bvalid");
		end else begin
			check_value("s_axi_bresp", s_axi_bresp, 32'h0);     // OKAY
		end
		@(negedge mpeg_clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int cnt;
		cnt = 0;
		@(negedge mpeg_clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		while (!s_axi_arready && cnt < wait_limit) begin
			@(negedge mpeg_clk);
			cnt++;
		end
		if (cnt == wait_limit) report_timeout("arready");
		@(negedge mpeg_clk);
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b1;
		cnt = 0;
		while (!s_axi_rvalid && cnt < wait_limit) begin
			@(negedge mpeg_clk);
			cnt++;
		end
		if (cnt == wait_limit) begin
			report_timeout("rvalid");
		end else begin
			check_value("s_axi_rresp", s_axi_rresp, 32'h0);     // OKAY
		end
		data = s_axi_rdata;               // Held stable while rvalid is up
		@(negedge mpeg_clk);
		s_axi_rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stream driver and packet checks
	////////////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] data, input logic sync, input logic gaps);
		int idle;
		idle = gaps ? int'($unsigned($random(seed)) % 3) : 0;
		repeat (idle) begin
			@(negedge mpeg_clk);
			mpeg_valid = 1'b0;
		end
		@(negedge mpeg_clk);
		mpeg_data = data;
		mpeg_sync = sync;
		mpeg_valid = 1'b1;
	endtask

	task automatic stop_stream();
		@(negedge mpeg_clk);
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
	endtask

	task automatic send_packet(input logic [12:0] pid, input logic [7:0] first,
		input logic gaps);
		for (int k = 0; k < 188; k++) begin
			send_byte(packet_byte(pid, first, k), k == 0, gaps);
		end
		stop_stream();
	endtask

	task automatic check_packet(input logic [12:0] pid, input logic [7:0] first);
		logic [31:0] got;
		logic [31:0] exp;
		for (int j = 0; j < 47 && !timed_out; j++) begin
			axi_read(8'h40 + 8'(4 * j), got);
			exp = {packet_byte(pid, first, 4 * j + 3), packet_byte(pid, first, 4 * j + 2),
				packet_byte(pid, first, 4 * j + 1), packet_byte(pid, first, 4 * j)};
			check_value($sformatf("s_axi_rdata word %0d", j), got, exp);
		end
	endtask

	task automatic check_counts(input logic [31:0] ready, input logic [31:0] pkts,
		input logic [31:0] drops);
		logic [31:0] got;
		axi_read(8'h08, got);
		check_value("pkt_ready", got, ready);
		axi_read(8'h10, got);
		check_value("pkt_count", got, pkts);
		axi_read(8'h14, got);
		check_value("drop_count", got, drops);
	endtask

	initial begin
		integer fd;
		integer code;
		integer test_start;
		logic [7:0] cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] got;
		logic [8*120-1:0] rest;
		S_AXI_ARESETN = 1'b0;
		mpeg_data = 8'h00;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		test_start = 0;
		repeat (16) @(posedge mpeg_clk);
		@(negedge mpeg_clk);
		S_AXI_ARESETN = 1'b1;

		fd = $fopen("sim/ts_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end else begin
			code = $fscanf(fd, " %c", cmd);
			while (code == 1 && !timed_out) begin
				case (cmd)
					"#": code = $fgets(rest, fd);   // Comment line
					"W": begin
						code = $fscanf(fd, "%h %h", a, b);
						axi_write(a[7:0], b);
					end
					"R": begin
						code = $fscanf(fd, "%h %h", a, b);
						axi_read(a[7:0], got);
						check_value("s_axi_rdata", got, b);
					end
					"P": begin
						code = $fscanf(fd, "%h %h %h", a, b, c);
						send_packet(a[12:0], b[7:0], c[0]);
					end
					"I": begin
						code = $fscanf(fd, "%h", a);
						for (int i = 0; i < a; i++) begin
							send_byte(8'hFF, 1'b0, 1'b0);
						end
						stop_stream();
					end
					"C": begin
						code = $fscanf(fd, "%h %h", a, b);
						check_packet(a[12:0], b[7:0]);
					end
					"A": axi_write(8'h0C, 32'h1);
					"K": begin
						code = $fscanf(fd, "%h %h %h", a, b, c);
						check_counts(a, b, c);
					end
					"E": begin
						code = $fscanf(fd, "%h", a);
						$display("Test %0d finished with %0d errors", a, errors - test_start);
						test_start = errors;
						tests_done++;
					end
					default: begin
						$display("Unknown command %c in the stimulus file", cmd);
						errors++;
					end
				endcase
				code = $fscanf(fd, " %c", cmd);
			end
			$fclose(fd);
		end

		$display("Tests run %0d, errors %0d", tests_done, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: sim/ts_stimulus.txt
# Hex fields: W addr data, R addr expected, P pid first gaps, I count, C pid first
# A acknowledges, K ready captured dropped, E test number ends a test
R 08 0
W 04 1FFF
R 04 1FFF
W 04 0100
W 00 1
R 04 0100
R 00 1
E 1
I 8
P 0100 00 0
I 4
K 1 1 0
C 0100 00
A
K 0 1 0
E 2
P 0101 10 0
I 4
W 00 0
P 0100 20 0
I 4
K 0 1 0
W 00 1
E 3
P 0100 30 0
P 0100 60 0
I 4
K 1 2 1
C 0100 30
A
K 0 2 1
P 0100 90 0
I 4
K 1 3 1
C 0100 90
A
E 4
P 0100 C0 1
I 4
K 1 4 1
C 0100 C0
A
E 5

// File: filelist.f
design/ts_monitor_pkg.sv
design/ts_sync_detector.sv
design/ts_packet_capture.sv
design/ts_packet_buffer.sv
design/ts_monitor_ctrl.sv
design/ts_monitor_top.sv
sim/tb_ts_monitor.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_ts_monitor
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
